/* rtl/rv_decode_params.svh */
// RV64 decode widths
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// data path width of the core
`define XLEN 64

// raw instruction word width
`define INST_W 32

// architectural register index width
`define REG_IDX_W 5

// a0, return value register
// ecall results are written here
`define REG_A0 10

`endif

/* rtl/rv_decode_pkg.sv */
// RV64 decode types
`include "rv_decode_params.svh"

package rv_decode_pkg;

    // meaningful widths
    typedef logic [`INST_W-1:0]    inst_t;
    typedef logic [`XLEN-1:0]      xlen_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;
    typedef logic [2:0]            funct3_t;
    typedef logic [6:0]            funct7_t;

    // base opcodes, inst[6:0]
    typedef enum logic [6:0] {
        op_lui       = 7'b0110111,
        op_auipc     = 7'b0010111,
        op_jal       = 7'b1101111,
        op_jalr      = 7'b1100111,
        op_branch    = 7'b1100011,
        op_load      = 7'b0000011,
        op_store     = 7'b0100011,
        op_op_imm    = 7'b0010011,
        op_op_imm_32 = 7'b0011011,
        op_op        = 7'b0110011,
        op_op_32     = 7'b0111011,
        op_misc_mem  = 7'b0001111,
        op_system    = 7'b1110011
    } opcode_e;

    // ALU funct3 codes that the decoder produces itself
    typedef enum logic [2:0] {
        f3op_add_sub = 3'b000,
        f3op_slt     = 3'b010,
        f3op_sltu    = 3'b011,
        f3op_srx     = 3'b101
    } f3_op_e;

    // branch funct3, 3'b010 and 3'b011 unused
    typedef enum logic [2:0] {
        f3b_beq  = 3'b000,
        f3b_bne  = 3'b001,
        f3b_blt  = 3'b100,
        f3b_bge  = 3'b101,
        f3b_bltu = 3'b110,
        f3b_bgeu = 3'b111
    } f3_branch_e;

    // when the exec stage redirects the PC
    typedef enum logic [2:0] {
        jump_no      = 3'd0,
        jump_yes     = 3'd1,
        jump_alu_eqz = 3'd2,
        jump_alu_nez = 3'd3
    } jump_code_e;

    // immediate layout select
    typedef enum logic [2:0] {
        imm_none = 3'd0,
        imm_i    = 3'd1,
        imm_s    = 3'd2,
        imm_sb   = 3'd3,
        imm_u    = 3'd4,
        imm_uj   = 3'd5
    } imm_fmt_e;

    // how funct3/funct7 reach the ALU
    typedef enum logic [2:0] {
        mode_add    = 3'd0,
        mode_inst   = 3'd1,
        mode_imm    = 3'd2,
        mode_branch = 3'd3,
        mode_none   = 3'd4
    } alu_mode_e;

    // opcode class controls
    typedef struct packed {
        imm_fmt_e  imm_fmt;
        alu_mode_e alu_mode;
        logic      en_rs1;
        logic      en_rs2;
        logic      en_rd;
        logic      zero_rs1;
        logic      rd_to_a0;
        logic      alu_use_immed;
        logic      alu_width_32;
        logic      keep_pc_plus_immed;
        logic      jump_uncond;
        logic      jump_absolute;
        logic      is_ecall;
        logic      illegal_op;
    } ctrl_sig_t;

    // ALU op and jump condition
    typedef struct packed {
        funct3_t    funct3;
        funct7_t    funct7;
        jump_code_e jump_if;
        logic       bad_funct3;
    } alu_sel_t;

    // decoded record handed to the exec stage
    typedef struct packed {
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        reg_idx_t   rd;
        logic       en_rs1;
        logic       en_rs2;
        logic       en_rd;
        xlen_t      immed;
        logic       keep_pc_plus_immed;
        logic       alu_use_immed;
        logic       alu_width_32;
        funct3_t    funct3;
        funct7_t    funct7;
        jump_code_e jump_if;
        logic       jump_absolute;
        logic       is_ecall;
        logic       illegal;
    } decoded_inst_t;

endpackage

/* rtl/decode_ctrl.sv */
// Opcode classification
`timescale 1ns/1ps

module decode_ctrl (
    input  rv_decode_pkg::inst_t     inst,
    output rv_decode_pkg::ctrl_sig_t ctrl
);

    rv_decode_pkg::opcode_e opcode;
    rv_decode_pkg::funct3_t funct3;

    assign opcode = rv_decode_pkg::opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];

    always_comb begin
        // quiet defaults, each opcode sets only what it needs
        ctrl                    = '0;
        ctrl.imm_fmt            = rv_decode_pkg::imm_none;
        ctrl.alu_mode           = rv_decode_pkg::mode_none;

        case (opcode)
            // 0 + imm through the ALU
            rv_decode_pkg::op_lui: begin
                ctrl.imm_fmt       = rv_decode_pkg::imm_u;
                ctrl.alu_mode      = rv_decode_pkg::mode_add;
                ctrl.alu_use_immed = 1'b1;
                ctrl.zero_rs1      = 1'b1;
                ctrl.en_rd         = 1'b1;
            end
            // separate PC adder picks up the ALU result
            rv_decode_pkg::op_auipc: begin
                ctrl.imm_fmt            = rv_decode_pkg::imm_u;
                ctrl.alu_mode           = rv_decode_pkg::mode_add;
                ctrl.alu_use_immed      = 1'b1;
                ctrl.keep_pc_plus_immed = 1'b1;
                ctrl.en_rd              = 1'b1;
            end
            // pc relative, only the link register
            rv_decode_pkg::op_jal: begin
                ctrl.imm_fmt       = rv_decode_pkg::imm_uj;
                ctrl.alu_mode      = rv_decode_pkg::mode_add;
                ctrl.alu_use_immed = 1'b1;
                ctrl.zero_rs1      = 1'b1;
                ctrl.en_rd         = 1'b1;
                ctrl.jump_uncond   = 1'b1;
            end
            // target is rs1 + imm from the ALU
            rv_decode_pkg::op_jalr: begin
                ctrl.imm_fmt       = rv_decode_pkg::imm_i;
                ctrl.alu_mode      = rv_decode_pkg::mode_add;
                ctrl.alu_use_immed = 1'b1;
                ctrl.en_rs1        = 1'b1;
                ctrl.en_rd         = 1'b1;
                ctrl.jump_uncond   = 1'b1;
                ctrl.jump_absolute = 1'b1;
            end
            // compare rs1 with rs2, target is PC + imm
            rv_decode_pkg::op_branch: begin
                ctrl.imm_fmt  = rv_decode_pkg::imm_sb;
                ctrl.alu_mode = rv_decode_pkg::mode_branch;
                ctrl.en_rs1   = 1'b1;
                ctrl.en_rs2   = 1'b1;
            end
            // address calc rs1 + imm
            rv_decode_pkg::op_load: begin
                ctrl.imm_fmt       = rv_decode_pkg::imm_i;
                ctrl.alu_mode      = rv_decode_pkg::mode_add;
                ctrl.alu_use_immed = 1'b1;
                ctrl.en_rs1        = 1'b1;
                ctrl.en_rd         = 1'b1;
            end
            // rs2 carries the store data
            rv_decode_pkg::op_store: begin
                ctrl.imm_fmt       = rv_decode_pkg::imm_s;
                ctrl.alu_mode      = rv_decode_pkg::mode_add;
                ctrl.alu_use_immed = 1'b1;
                ctrl.en_rs1        = 1'b1;
                ctrl.en_rs2        = 1'b1;
            end
            rv_decode_pkg::op_op_imm, rv_decode_pkg::op_op_imm_32: begin
                ctrl.imm_fmt       = rv_decode_pkg::imm_i;
                ctrl.alu_mode      = rv_decode_pkg::mode_imm;
                ctrl.alu_use_immed = 1'b1;
                ctrl.en_rs1        = 1'b1;
                ctrl.en_rd         = 1'b1;
                ctrl.alu_width_32  = (opcode == rv_decode_pkg::op_op_imm_32);
            end
            // register-register, ALU codes straight from the word
            rv_decode_pkg::op_op, rv_decode_pkg::op_op_32: begin
                ctrl.alu_mode     = rv_decode_pkg::mode_inst;
                ctrl.en_rs1       = 1'b1;
                ctrl.en_rs2       = 1'b1;
                ctrl.en_rd        = 1'b1;
                ctrl.alu_width_32 = (opcode == rv_decode_pkg::op_op_32);
            end
            // fence, nothing read or written
            rv_decode_pkg::op_misc_mem: begin
                ctrl.alu_mode = rv_decode_pkg::mode_none;
            end
            rv_decode_pkg::op_system: begin
                ctrl.alu_mode = rv_decode_pkg::mode_none;
                // ecall only, ebreak has bit 20 set and stays a no-op
                if (funct3 == 3'b000 && !inst[20]) begin
                    ctrl.is_ecall = 1'b1;
                    // host call result lands in a0
                    ctrl.rd_to_a0 = 1'b1;
                    ctrl.en_rd    = 1'b1;
                end
            end
            default: begin
                // unknown opcode, enables stay low
                ctrl.illegal_op = 1'b1;
            end
        endcase
    end

endmodule

/* rtl/imm_gen.sv */
// Immediate construction
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::inst_t    inst,
    input  rv_decode_pkg::imm_fmt_e imm_fmt,
    output rv_decode_pkg::xlen_t    immed
);

    rv_decode_pkg::xlen_t imm_i;
    rv_decode_pkg::xlen_t imm_s;
    rv_decode_pkg::xlen_t imm_sb;
    rv_decode_pkg::xlen_t imm_u;
    rv_decode_pkg::xlen_t imm_uj;

    // all layouts sign extend from inst[31]
    assign imm_i  = {{52{inst[31]}}, inst[31:20]};
    // split around rd field
    assign imm_s  = {{52{inst[31]}}, inst[31:25], inst[11:7]};
    // halfword aligned branch offset
    assign imm_sb = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    // upper 20 bits with low 12 zero
    assign imm_u  = {{32{inst[31]}}, inst[31:12], 12'b0};
    // halfword aligned jal offset
    assign imm_uj = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    always_comb begin
        case (imm_fmt)
            rv_decode_pkg::imm_i:  immed = imm_i;
            rv_decode_pkg::imm_s:  immed = imm_s;
            rv_decode_pkg::imm_sb: immed = imm_sb;
            rv_decode_pkg::imm_u:  immed = imm_u;
            rv_decode_pkg::imm_uj: immed = imm_uj;
            default:               immed = '0;
        endcase
    end

endmodule

/* rtl/alu_op_sel.sv */
// ALU and branch op select
`timescale 1ns/1ps

module alu_op_sel (
    input  rv_decode_pkg::inst_t     inst,
    input  rv_decode_pkg::alu_mode_e alu_mode,
    input  logic                     jump_uncond,
    output rv_decode_pkg::alu_sel_t  sel
);

    rv_decode_pkg::funct3_t funct3;
    rv_decode_pkg::funct7_t funct7;

    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        sel            = '0;
        // non-branch jump kind
        sel.jump_if    = jump_uncond ? rv_decode_pkg::jump_yes : rv_decode_pkg::jump_no;

        case (alu_mode)
            // address and immediate adds
            rv_decode_pkg::mode_add: begin
                sel.funct3 = rv_decode_pkg::f3op_add_sub;
                sel.funct7 = 7'b000_0000;
            end
            rv_decode_pkg::mode_inst: begin
                sel.funct3 = funct3;
                sel.funct7 = funct7;
            end
            // upper imm bits are immediate, except the SRAI flag
            rv_decode_pkg::mode_imm: begin
                sel.funct3 = funct3;
                sel.funct7 = 7'b000_0000;
                if (funct3 == rv_decode_pkg::f3op_srx) begin
                    sel.funct7[5] = funct7[5];
                end
            end
            // ALU result tested against zero
            rv_decode_pkg::mode_branch: begin
                case (funct3)
                    // difference zero means equal
                    rv_decode_pkg::f3b_beq: begin
                        sel.funct3  = rv_decode_pkg::f3op_add_sub;
                        sel.funct7  = 7'b010_0000;
                        sel.jump_if = rv_decode_pkg::jump_alu_eqz;
                    end
                    rv_decode_pkg::f3b_bne: begin
                        sel.funct3  = rv_decode_pkg::f3op_add_sub;
                        sel.funct7  = 7'b010_0000;
                        sel.jump_if = rv_decode_pkg::jump_alu_nez;
                    end
                    // slt gives 1 when less than
                    rv_decode_pkg::f3b_blt: begin
                        sel.funct3  = rv_decode_pkg::f3op_slt;
                        sel.jump_if = rv_decode_pkg::jump_alu_nez;
                    end
                    rv_decode_pkg::f3b_bge: begin
                        sel.funct3  = rv_decode_pkg::f3op_slt;
                        sel.jump_if = rv_decode_pkg::jump_alu_eqz;
                    end
                    rv_decode_pkg::f3b_bltu: begin
                        sel.funct3  = rv_decode_pkg::f3op_sltu;
                        sel.jump_if = rv_decode_pkg::jump_alu_nez;
                    end
                    rv_decode_pkg::f3b_bgeu: begin
                        sel.funct3  = rv_decode_pkg::f3op_sltu;
                        sel.jump_if = rv_decode_pkg::jump_alu_eqz;
                    end
                    default: begin
                        // 3'b010 / 3'b011, never jump
                        sel.jump_if    = rv_decode_pkg::jump_no;
                        sel.bad_funct3 = 1'b1;
                    end
                endcase
            end
            // mode_none and spare codes give zero fields
            default: begin
                sel.funct3 = 3'b000;
                sel.funct7 = 7'b000_0000;
            end
        endcase
    end

endmodule

/* rtl/decode_reg.sv */
// Decode output register
`timescale 1ns/1ps
`include "rv_decode_params.svh"

module decode_reg (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         inst_valid,
    input  rv_decode_pkg::inst_t         inst,
    input  rv_decode_pkg::ctrl_sig_t     ctrl,
    input  rv_decode_pkg::xlen_t         immed,
    input  rv_decode_pkg::alu_sel_t      sel,
    output logic                         dec_valid,
    output rv_decode_pkg::decoded_inst_t dec
);

    rv_decode_pkg::decoded_inst_t rec;
    logic                         illegal;

    assign illegal = ctrl.illegal_op | sel.bad_funct3;

    always_comb begin
        // register fields from the fixed RISC-V positions
        rec.rs1    = ctrl.zero_rs1 ? '0 : inst[19:15];
        rec.rs2    = inst[24:20];
        rec.rd     = ctrl.rd_to_a0 ? `REG_IDX_W'(`REG_A0) : inst[11:7];
        // hazard logic must ignore an illegal word
        rec.en_rs1 = ctrl.en_rs1 & ~illegal;
        rec.en_rs2 = ctrl.en_rs2 & ~illegal;
        rec.en_rd  = ctrl.en_rd & ~illegal;
        rec.immed  = immed;
        rec.keep_pc_plus_immed = ctrl.keep_pc_plus_immed;
        rec.alu_use_immed      = ctrl.alu_use_immed;
        rec.alu_width_32       = ctrl.alu_width_32;
        rec.funct3        = sel.funct3;
        rec.funct7        = sel.funct7;
        rec.jump_if       = sel.jump_if;
        rec.jump_absolute = ctrl.jump_absolute;
        rec.is_ecall      = ctrl.is_ecall;
        rec.illegal       = illegal;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            dec       <= '0;
        end else begin
            dec_valid <= inst_valid;
            // record holds across idle cycles
            if (inst_valid) begin
                dec <= rec;
            end
        end
    end

    // illegal record never redirects the PC
    illegal_no_jump: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid && dec.illegal |-> dec.jump_if == rv_decode_pkg::jump_no
    ) else $error("illegal record with a jump condition");

    // ecall reads no register and writes only a0
    ecall_to_a0: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid && dec.is_ecall |->
            dec.en_rd && !dec.en_rs1 && !dec.en_rs2 && dec.rd == `REG_IDX_W'(`REG_A0)
    ) else $error("ecall record not aimed at a0");

endmodule

/* rtl/rv_decoder.sv */
// RV64 decode stage top
`timescale 1ns/1ps

module rv_decoder (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         inst_valid,
    input  rv_decode_pkg::inst_t         inst,
    output logic                         dec_valid,
    output rv_decode_pkg::decoded_inst_t dec
);

    rv_decode_pkg::ctrl_sig_t ctrl;
    rv_decode_pkg::xlen_t     immed;
    rv_decode_pkg::alu_sel_t  sel;

    // opcode class
    decode_ctrl u_decode_ctrl (
        .inst (inst),
        .ctrl (ctrl)
    );

    // immediate unscramble
    imm_gen u_imm_gen (
        .inst    (inst),
        .imm_fmt (ctrl.imm_fmt),
        .immed   (immed)
    );

    // ALU fields and jump condition
    alu_op_sel u_alu_op_sel (
        .inst        (inst),
        .alu_mode    (ctrl.alu_mode),
        .jump_uncond (ctrl.jump_uncond),
        .sel         (sel)
    );

    // one cycle to the exec stage
    decode_reg u_decode_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .ctrl       (ctrl),
        .immed      (immed),
        .sel        (sel),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

endmodule

/* testbench/tb_rv_decoder.sv */
// Decoder regression testbench
`timescale 1ns/1ps

module tb_rv_decoder;

    logic                         clk;
    logic                         rst_n;
    logic                         inst_valid;
    rv_decode_pkg::inst_t         inst;
    logic                         dec_valid;
    rv_decode_pkg::decoded_inst_t dec;

    // jump condition codes as plain vectors for the table rows
    localparam logic [2:0] j_no  = 3'd0;
    localparam logic [2:0] j_yes = 3'd1;
    localparam logic [2:0] j_eqz = 3'd2;
    localparam logic [2:0] j_nez = 3'd3;

    // stimulus table, one entry per cycle
    logic                         vec_valid[$];
    rv_decode_pkg::inst_t         vec_inst[$];
    rv_decode_pkg::decoded_inst_t vec_exp[$];

    // what the output must show at the next check
    logic                         pend_valid;
    rv_decode_pkg::decoded_inst_t last_rec;

    logic [15:0] lfsr;
    int          cycles;
    int          cycle_limit = 1000;

    rv_decoder uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // galois LFSR, taps 16,14,13,11
    function automatic logic next_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b) lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    // one LFSR step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] r;
        r = '0;
        for (int k = 0; k < n; k++) r = {r[14:0], next_bit()};
        return r;
    endfunction

    // instruction encoders, straight from the ISA field layouts
    function automatic rv_decode_pkg::inst_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                                   logic [2:0] f3, logic [4:0] rd,
                                                   logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rv_decode_pkg::inst_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                                   logic [4:0] rs1, logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv_decode_pkg::inst_t enc_b(logic [12:0] imm, logic [4:0] rs2,
                                                   logic [4:0] rs1, logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic rv_decode_pkg::inst_t enc_u(logic [19:0] imm, logic [4:0] rd,
                                                   logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rv_decode_pkg::inst_t enc_j(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic rv_decode_pkg::inst_t enc_r(logic [6:0] f7, logic [4:0] rs2,
                                                   logic [4:0] rs1, logic [2:0] f3,
                                                   logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // rsel {rs1 zeroed, rd to a0}, alu {pc add, use imm, 32 bit}, misc {abs, ecall, illegal}
    task automatic add_vec(rv_decode_pkg::inst_t w, logic [1:0] rsel, logic [2:0] en,
                           rv_decode_pkg::xlen_t immed, logic [2:0] f3, logic [6:0] f7,
                           logic [2:0] alu, logic [2:0] j, logic [2:0] misc);
        rv_decode_pkg::decoded_inst_t e;
        e.rs1 = rsel[1] ? 5'd0 : w[19:15];
        e.rs2 = w[24:20];
        // a0 is x10
        e.rd  = rsel[0] ? 5'd10 : w[11:7];
        {e.en_rs1, e.en_rs2, e.en_rd} = en;
        e.immed = immed;
        {e.keep_pc_plus_immed, e.alu_use_immed, e.alu_width_32} = alu;
        e.funct3  = f3;
        e.funct7  = f7;
        e.jump_if = rv_decode_pkg::jump_code_e'(j);
        {e.jump_absolute, e.is_ecall, e.illegal} = misc;
        vec_valid.push_back(1'b1);
        vec_inst.push_back(w);
        vec_exp.push_back(e);
    endtask

    // cycle without a strobe, word on the bus is junk
    task automatic add_idle(rv_decode_pkg::inst_t w);
        vec_valid.push_back(1'b0);
        vec_inst.push_back(w);
        vec_exp.push_back('0);
    endtask

    task automatic build_table();
        // upper immediates
        add_vec(enc_u(20'h80001, 5'd5, rv_decode_pkg::op_lui), 2'b10, 3'b001,
                64'hFFFF_FFFF_8000_1000, 3'h0, 7'h00, 3'b010, j_no, 3'b000);
        add_vec(enc_u(20'h12345, 5'd7, rv_decode_pkg::op_auipc), 2'b00, 3'b001,
                64'h0000_0000_1234_5000, 3'h0, 7'h00, 3'b110, j_no, 3'b000);
        // jumps
        add_vec(enc_j(21'h1F_FFF8, 5'd1), 2'b10, 3'b001,
                64'hFFFF_FFFF_FFFF_FFF8, 3'h0, 7'h00, 3'b010, j_yes, 3'b000);
        add_vec(enc_j(21'h00_0800, 5'd1), 2'b10, 3'b001,
                64'h0000_0000_0000_0800, 3'h0, 7'h00, 3'b010, j_yes, 3'b000);
        add_vec(enc_i(12'h010, 5'd6, 3'b000, 5'd1, rv_decode_pkg::op_jalr), 2'b00, 3'b101,
                64'h10, 3'h0, 7'h00, 3'b010, j_yes, 3'b100);
        // memory
        add_vec(enc_i(12'h008, 5'd2, 3'b011, 5'd4, rv_decode_pkg::op_load), 2'b00, 3'b101,
                64'h8, 3'h0, 7'h00, 3'b010, j_no, 3'b000);
        add_vec(enc_s(12'hFF8, 5'd5, 5'd2, 3'b011), 2'b00, 3'b110,
                64'hFFFF_FFFF_FFFF_FFF8, 3'h0, 7'h00, 3'b010, j_no, 3'b000);
        // immediate ALU ops, funct7 cleared except the SRAI bit
        add_vec(enc_i(12'hFFF, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op_imm), 2'b00, 3'b101,
                64'hFFFF_FFFF_FFFF_FFFF, 3'h0, 7'h00, 3'b010, j_no, 3'b000);
        add_vec(enc_i(12'h7FF, 5'd1, 3'b111, 5'd3, rv_decode_pkg::op_op_imm), 2'b00, 3'b101,
                64'h7FF, 3'h7, 7'h00, 3'b010, j_no, 3'b000);
        add_idle(32'hDEAD_BEEF);
        add_vec(enc_i(12'h03F, 5'd1, 3'b101, 5'd3, rv_decode_pkg::op_op_imm), 2'b00, 3'b101,
                64'h3F, 3'h5, 7'h00, 3'b010, j_no, 3'b000);
        add_vec(enc_i(12'h405, 5'd1, 3'b101, 5'd3, rv_decode_pkg::op_op_imm), 2'b00, 3'b101,
                64'h405, 3'h5, 7'h20, 3'b010, j_no, 3'b000);
        add_vec(enc_i(12'h001, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op_imm_32), 2'b00,
                3'b101, 64'h1, 3'h0, 7'h00, 3'b011, j_no, 3'b000);
        // register ops pass funct7 through
        add_vec(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op), 2'b00, 3'b111,
                64'h0, 3'h0, 7'h20, 3'b000, j_no, 3'b000);
        add_vec(enc_r(7'h01, 5'd2, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op), 2'b00, 3'b111,
                64'h0, 3'h0, 7'h01, 3'b000, j_no, 3'b000);
        add_vec(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, rv_decode_pkg::op_op_32), 2'b00, 3'b111,
                64'h0, 3'h0, 7'h00, 3'b001, j_no, 3'b000);
        add_idle(32'h0000_0000);
        add_idle(32'hFFFF_FFFF);
        // the six branches
        add_vec(enc_b(13'h0010, 5'd2, 5'd1, 3'b000), 2'b00, 3'b110,
                64'h10, 3'h0, 7'h20, 3'b000, j_eqz, 3'b000);
        add_vec(enc_b(13'h0010, 5'd2, 5'd1, 3'b001), 2'b00, 3'b110,
                64'h10, 3'h0, 7'h20, 3'b000, j_nez, 3'b000);
        add_vec(enc_b(13'h0010, 5'd2, 5'd1, 3'b100), 2'b00, 3'b110,
                64'h10, 3'h2, 7'h00, 3'b000, j_nez, 3'b000);
        add_vec(enc_b(13'h0010, 5'd2, 5'd1, 3'b101), 2'b00, 3'b110,
                64'h10, 3'h2, 7'h00, 3'b000, j_eqz, 3'b000);
        add_vec(enc_b(13'h0010, 5'd2, 5'd1, 3'b110), 2'b00, 3'b110,
                64'h10, 3'h3, 7'h00, 3'b000, j_nez, 3'b000);
        add_vec(enc_b(13'h0010, 5'd2, 5'd1, 3'b111), 2'b00, 3'b110,
                64'h10, 3'h3, 7'h00, 3'b000, j_eqz, 3'b000);
        // offset extremes
        add_vec(enc_b(13'h1000, 5'd2, 5'd1, 3'b000), 2'b00, 3'b110,
                64'hFFFF_FFFF_FFFF_F000, 3'h0, 7'h20, 3'b000, j_eqz, 3'b000);
        add_vec(enc_b(13'h0FFE, 5'd2, 5'd1, 3'b100), 2'b00, 3'b110,
                64'hFFE, 3'h2, 7'h00, 3'b000, j_nez, 3'b000);
        // illegal words drop every enable
        add_vec(enc_b(13'h0008, 5'd2, 5'd1, 3'b010), 2'b00, 3'b000,
                64'h8, 3'h0, 7'h00, 3'b000, j_no, 3'b001);
        add_vec(enc_b(13'h0008, 5'd2, 5'd1, 3'b011), 2'b00, 3'b000,
                64'h8, 3'h0, 7'h00, 3'b000, j_no, 3'b001);
        add_vec(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h7F), 2'b00, 3'b000,
                64'h0, 3'h0, 7'h00, 3'b000, j_no, 3'b001);
        // ecall, ebreak, fence
        add_vec(32'h0000_0073, 2'b01, 3'b001, 64'h0, 3'h0, 7'h00, 3'b000, j_no, 3'b010);
        add_vec(32'h0010_0073, 2'b00, 3'b000, 64'h0, 3'h0, 7'h00, 3'b000, j_no, 3'b000);
        add_vec(32'h0FF0_000F, 2'b00, 3'b000, 64'h0, 3'h0, 7'h00, 3'b000, j_no, 3'b000);
    endtask

    // ADDI, SD and BEQ with LFSR immediates and registers
    task automatic add_random();
        logic [15:0]          r;
        logic [11:0]          imm;
        logic [12:0]          off;
        logic [4:0]           ra;
        logic [4:0]           rb;
        rv_decode_pkg::inst_t w;
        for (int k = 0; k < 8; k++) begin
            r   = rand_bits(12);
            imm = r[11:0];
            r   = rand_bits(5);
            ra  = r[4:0];
            r   = rand_bits(5);
            rb  = r[4:0];
            w   = enc_i(imm, ra, 3'b000, rb, rv_decode_pkg::op_op_imm);
            add_vec(w, 2'b00, 3'b101, {{52{imm[11]}}, imm}, 3'h0, 7'h00, 3'b010, j_no, 3'b000);
            w   = enc_s(imm, rb, ra, 3'b011);
            add_vec(w, 2'b00, 3'b110, {{52{imm[11]}}, imm}, 3'h0, 7'h00, 3'b010, j_no, 3'b000);
            // branch offset, low bit always zero
            r   = rand_bits(12);
            off = {r[11:0], 1'b0};
            w   = enc_b(off, rb, ra, 3'b000);
            add_vec(w, 2'b00, 3'b110, {{51{off[12]}}, off}, 3'h0, 7'h20, 3'b000, j_eqz, 3'b000);
        end
    endtask

    task automatic check_field(string name, logic [63:0] exp_v, logic [63:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, exp_v, act_v);
            $display("Regression failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_rec(rv_decode_pkg::decoded_inst_t e,
                               rv_decode_pkg::decoded_inst_t a);
        check_field("dec.rs1", 64'(e.rs1), 64'(a.rs1));
        check_field("dec.rs2", 64'(e.rs2), 64'(a.rs2));
        check_field("dec.rd", 64'(e.rd), 64'(a.rd));
        check_field("dec.en_rs1", 64'(e.en_rs1), 64'(a.en_rs1));
        check_field("dec.en_rs2", 64'(e.en_rs2), 64'(a.en_rs2));
        check_field("dec.en_rd", 64'(e.en_rd), 64'(a.en_rd));
        check_field("dec.immed", e.immed, a.immed);
        check_field("dec.keep_pc_plus_immed", 64'(e.keep_pc_plus_immed),
                    64'(a.keep_pc_plus_immed));
        check_field("dec.alu_use_immed", 64'(e.alu_use_immed), 64'(a.alu_use_immed));
        check_field("dec.alu_width_32", 64'(e.alu_width_32), 64'(a.alu_width_32));
        check_field("dec.funct3", 64'(e.funct3), 64'(a.funct3));
        check_field("dec.funct7", 64'(e.funct7), 64'(a.funct7));
        check_field("dec.jump_if", 64'(e.jump_if), 64'(a.jump_if));
        check_field("dec.jump_absolute", 64'(e.jump_absolute), 64'(a.jump_absolute));
        check_field("dec.is_ecall", 64'(e.is_ecall), 64'(a.is_ecall));
        check_field("dec.illegal", 64'(e.illegal), 64'(a.illegal));
    endtask

    // check what the last edge produced, then drive the next entry
    task automatic run_cycle(logic v, rv_decode_pkg::inst_t w,
                             rv_decode_pkg::decoded_inst_t e);
        @(posedge clk);
        #1;
        check_field("dec_valid", 64'(pend_valid), 64'(dec_valid));
        // idle cycles expect the held record
        compare_rec(last_rec, dec);
        inst_valid = v;
        inst       = w;
        pend_valid = v;
        if (v) last_rec = e;
    endtask

    initial begin
        rst_n      = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        pend_valid = 1'b0;
        last_rec   = '0;
        lfsr       = 16'd23;
        build_table();
        add_random();
        cycle_limit = 2 * vec_inst.size() + 50;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // first check sees the reset state, valid low and record zero
        for (int i = 0; i < vec_inst.size(); i++) begin
            run_cycle(vec_valid[i], vec_inst[i], vec_exp[i]);
        end
        // flush the last entry, then confirm it holds
        run_cycle(1'b0, 32'h0, '0);
        run_cycle(1'b0, 32'h0, '0);
        $display("Regression passed");
        $finish;
    end

    // watchdog on total cycles
    initial begin
        cycles = 0;
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Regression failed");
        $fatal(1, "cycle limit reached");
    end

endmodule

/* sim.f */
+incdir+rtl
rtl/rv_decode_pkg.sv
rtl/decode_ctrl.sv
rtl/imm_gen.sv
rtl/alu_op_sel.sv
rtl/decode_reg.sv
rtl/rv_decoder.sv
testbench/tb_rv_decoder.sv

/* Makefile */
# Verilator lint and regression for the RV64 decode stage

TOP := tb_rv_decoder
OBJ := obj_dir

.PHONY: sim lint clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

lint:
	verilator --lint-only --timing --assert -f sim.f --top-module $(TOP)

clean:
	rm -rf $(OBJ)
